//--- src/du_defines.svh
`ifndef DU_DEFINES_SVH
`define DU_DEFINES_SVH

// Data memory word width
`define DU_NB_DATA 32

// UART byte width
`define DU_NB_UART 8

// Data memory address width
`define DU_NB_ADDR 5

// Data memory depth in words
`define DU_MEM_WORDS 32

// Bytes per memory word, LSB first on the link
`define DU_BYTES_PER_WORD 4

`endif

//--- src/du_pkg.sv
`default_nettype none

`include "du_defines.svh"

package du_pkg;

    // Command opcodes, first byte of every frame
    typedef enum logic [`DU_NB_UART-1:0] {
        CMD_WRITE = 8'h01,
        CMD_DUMP  = 8'h02
    } du_cmd_e;

    // Command decoder states
    typedef enum logic [2:0] {
        OPCODE,
        ADDR,
        DATA,
        COUNT,
        ISSUE
    } du_rx_state_e;

    // Transmitter states, one-hot
    typedef enum logic [4:0] {
        IDLE = 5'b00001,
        READ = 5'b00010,
        LOAD = 5'b00100,
        SEND = 5'b01000,
        DONE = 5'b10000
    } du_tx_state_e;

    // Memory write port
    typedef struct packed {
        logic                   en;
        logic [`DU_NB_ADDR-1:0] addr;
        logic [`DU_NB_DATA-1:0] data;
    } dmem_wr_t;

    // Dump request, count holds words minus one
    typedef struct packed {
        logic                   valid;
        logic [`DU_NB_ADDR-1:0] addr;
        logic [`DU_NB_ADDR-1:0] count;
    } dump_req_t;

endpackage

`default_nettype wire

//--- src/du_cmd_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "du_defines.svh"

module du_cmd_rx (
    input  wire logic                   clk,
    input  wire logic                   i_rst,
    input  wire logic                   i_rx_done,
    input  wire logic [`DU_NB_UART-1:0] i_rx_data,
    output logic                        o_rd,
    input  wire logic                   i_tx_busy,
    output du_pkg::dmem_wr_t            o_wr,
    output du_pkg::dump_req_t           o_dump
);
    import du_pkg::*;

    du_rx_state_e           state_reg;
    du_rx_state_e           state_next;
    du_cmd_e                op_reg;
    du_cmd_e                op_next;
    logic [1:0]             byte_cnt_reg;
    logic [1:0]             byte_cnt_next;
    logic [`DU_NB_ADDR-1:0] addr_reg;
    logic [`DU_NB_ADDR-1:0] addr_next;
    logic [`DU_NB_ADDR-1:0] count_reg;
    logic [`DU_NB_ADDR-1:0] count_next;
    logic [`DU_NB_DATA-1:0] data_reg;
    logic [`DU_NB_DATA-1:0] data_next;

    // Pop only while a frame is being collected and no dump is running
    assign o_rd = i_rx_done && (state_reg != ISSUE) && !i_tx_busy;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_reg    <= OPCODE;
            op_reg       <= CMD_WRITE;
            byte_cnt_reg <= 2'd0;
        end else begin
            state_reg    <= state_next;
            op_reg       <= op_next;
            byte_cnt_reg <= byte_cnt_next;
        end
    end

    // Frame payload
    always_ff @(posedge clk) begin
        addr_reg  <= addr_next;
        count_reg <= count_next;
        data_reg  <= data_next;
    end

    always_comb begin
        state_next    = state_reg;
        op_next       = op_reg;
        byte_cnt_next = byte_cnt_reg;
        addr_next     = addr_reg;
        count_next    = count_reg;
        data_next     = data_reg;

        case (state_reg)
            OPCODE: begin
                // Unknown opcodes are popped and dropped here
                if (o_rd && (i_rx_data == CMD_WRITE || i_rx_data == CMD_DUMP)) begin
                    op_next    = du_cmd_e'(i_rx_data);
                    state_next = ADDR;
                end
            end
            ADDR: begin
                if (o_rd) begin
                    addr_next     = i_rx_data[`DU_NB_ADDR-1:0];
                    byte_cnt_next = 2'd0;
                    state_next    = (op_reg == CMD_WRITE) ? DATA : COUNT;
                end
            end
            DATA: begin
                if (o_rd) begin
                    // Newest byte enters at the top, first byte ends up as LSB
                    data_next     = {i_rx_data, data_reg[`DU_NB_DATA-1:`DU_NB_UART]};
                    byte_cnt_next = byte_cnt_reg + 2'd1;
                    if (byte_cnt_reg == 2'(`DU_BYTES_PER_WORD - 1)) begin
                        state_next = ISSUE;
                    end
                end
            end
            COUNT: begin
                if (o_rd) begin
                    count_next = i_rx_data[`DU_NB_ADDR-1:0];
                    state_next = ISSUE;
                end
            end
            ISSUE: begin
                state_next = OPCODE;
            end
            default: begin
                state_next = OPCODE;
            end
        endcase
    end

    // Strobes come from the registered ISSUE state
    always_comb begin
        o_wr.en      = (state_reg == ISSUE) && (op_reg == CMD_WRITE);
        o_wr.addr    = addr_reg;
        o_wr.data    = data_reg;
        o_dump.valid = (state_reg == ISSUE) && (op_reg == CMD_DUMP);
        o_dump.addr  = addr_reg;
        o_dump.count = count_reg;
    end

endmodule

`default_nettype wire

//--- src/du_dmem.sv
`timescale 1ns/1ps
`default_nettype none

`include "du_defines.svh"

module du_dmem (
    input  wire logic                   clk,
    input  wire du_pkg::dmem_wr_t       i_wr,
    input  wire logic                   i_rd_en,
    input  wire logic [`DU_NB_ADDR-1:0] i_rd_addr,
    output logic      [`DU_NB_DATA-1:0] o_rd_data
);

    logic [`DU_NB_DATA-1:0] mem [`DU_MEM_WORDS];
    logic [`DU_NB_DATA-1:0] rd_data_reg;

    // Write port
    always_ff @(posedge clk) begin
        if (i_wr.en) begin
            mem[i_wr.addr] <= i_wr.data;
        end
    end

    // Registered read, data shows up the cycle after the enable
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            rd_data_reg <= mem[i_rd_addr];
        end
    end

    assign o_rd_data = rd_data_reg;

endmodule

`default_nettype wire

//--- src/du_dmem_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "du_defines.svh"

module du_dmem_tx (
    input  wire logic                   clk,
    input  wire logic                   i_rst,
    input  wire du_pkg::dump_req_t      i_dump,
    output logic                        o_rd_en,
    output logic      [`DU_NB_ADDR-1:0] o_rd_addr,
    input  wire logic [`DU_NB_DATA-1:0] i_rd_data,
    input  wire logic                   i_tx_full,
    output logic                        o_tx_wr,
    output logic      [`DU_NB_UART-1:0] o_tx_data,
    output logic                        o_busy,
    output logic                        o_done
);
    import du_pkg::*;

    du_tx_state_e           state_reg;
    du_tx_state_e           state_next;
    logic [`DU_NB_ADDR-1:0] addr_reg;
    logic [`DU_NB_ADDR-1:0] addr_next;
    logic [`DU_NB_ADDR-1:0] words_left_reg;
    logic [`DU_NB_ADDR-1:0] words_left_next;
    logic [1:0]             byte_cnt_reg;
    logic [1:0]             byte_cnt_next;
    logic [`DU_NB_DATA-1:0] shift_reg;
    logic [`DU_NB_DATA-1:0] shift_next;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_reg      <= IDLE;
            addr_reg       <= '0;
            words_left_reg <= '0;
            byte_cnt_reg   <= 2'd0;
        end else begin
            state_reg      <= state_next;
            addr_reg       <= addr_next;
            words_left_reg <= words_left_next;
            byte_cnt_reg   <= byte_cnt_next;
        end
    end

    // Outgoing word
    always_ff @(posedge clk) begin
        shift_reg <= shift_next;
    end

    always_comb begin
        state_next      = state_reg;
        addr_next       = addr_reg;
        words_left_next = words_left_reg;
        byte_cnt_next   = byte_cnt_reg;
        shift_next      = shift_reg;
        o_rd_en         = 1'b0;
        o_tx_wr         = 1'b0;
        o_done          = 1'b0;

        case (state_reg)
            IDLE: begin
                if (i_dump.valid) begin
                    addr_next       = i_dump.addr;
                    words_left_next = i_dump.count;
                    state_next      = READ;
                end
            end
            READ: begin
                o_rd_en    = 1'b1;
                state_next = LOAD;
            end
            LOAD: begin
                // Memory output is valid now
                shift_next    = i_rd_data;
                byte_cnt_next = 2'd0;
                state_next    = SEND;
            end
            SEND: begin
                // Stall in place while the FIFO is full
                if (!i_tx_full) begin
                    o_tx_wr       = 1'b1;
                    shift_next    = shift_reg >> `DU_NB_UART;
                    byte_cnt_next = byte_cnt_reg + 2'd1;
                    if (byte_cnt_reg == 2'(`DU_BYTES_PER_WORD - 1)) begin
                        if (words_left_reg == '0) begin
                            state_next = DONE;
                        end else begin
                            words_left_next = words_left_reg - 1'b1;
                            // Wraps modulo memory depth
                            addr_next       = addr_reg + 1'b1;
                            state_next      = READ;
                        end
                    end
                end
            end
            DONE: begin
                o_done     = 1'b1;
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    assign o_rd_addr = addr_reg;
    assign o_tx_data = shift_reg[`DU_NB_UART-1:0];
    assign o_busy    = (state_reg == READ) || (state_reg == LOAD) || (state_reg == SEND);

endmodule

`default_nettype wire

//--- src/du_dmem_link.sv
`timescale 1ns/1ps
`default_nettype none

`include "du_defines.svh"

module du_dmem_link (
    input  wire logic                   clk,
    input  wire logic                   i_rst,
    // Receive FIFO, first-word fall-through
    input  wire logic                   i_rx_done,
    input  wire logic [`DU_NB_UART-1:0] i_rx_data,
    output logic                        o_rd,
    // Transmit FIFO
    input  wire logic                   i_tx_full,
    output logic                        o_tx_wr,
    output logic      [`DU_NB_UART-1:0] o_tx_data,
    output logic                        o_done
);
    import du_pkg::*;

    dmem_wr_t               dmem_wr;
    dump_req_t              dump_req;
    logic                   rd_en;
    logic [`DU_NB_ADDR-1:0] rd_addr;
    logic [`DU_NB_DATA-1:0] rd_data;
    logic                   tx_busy;

    // Frame decoder
    du_cmd_rx u_cmd_rx (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_rx_done (i_rx_done),
        .i_rx_data (i_rx_data),
        .o_rd      (o_rd),
        .i_tx_busy (tx_busy),
        .o_wr      (dmem_wr),
        .o_dump    (dump_req)
    );

    du_dmem u_dmem (
        .clk       (clk),
        .i_wr      (dmem_wr),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    // Dump engine, holds off the decoder while busy
    du_dmem_tx u_dmem_tx (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_dump    (dump_req),
        .o_rd_en   (rd_en),
        .o_rd_addr (rd_addr),
        .i_rd_data (rd_data),
        .i_tx_full (i_tx_full),
        .o_tx_wr   (o_tx_wr),
        .o_tx_data (o_tx_data),
        .o_busy    (tx_busy),
        .o_done    (o_done)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic o_clk,
    output logic o_rst
);

    localparam int HALF_PERIOD_NS = 4;
    localparam int RESET_CYCLES   = 10;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
    end

    // Release on a falling edge like every other input
    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/tb_du_dmem_link.sv
`timescale 1ns/1ps
`default_nettype none

`include "du_defines.svh"

module tb_du_dmem_link;

    localparam logic [7:0] OP_WRITE = 8'h01;
    localparam logic [7:0] OP_DUMP  = 8'h02;
    // Words returned by all dumps below
    localparam int DUMP_WORDS  = 1 + 4 + 6 + 6 + 1 + 2 + 1;
    localparam int WATCHDOG_NS = 2000 + 200 * DUMP_WORDS * `DU_BYTES_PER_WORD;

    logic                   clk;
    logic                   i_rst;
    logic                   i_rx_done;
    logic [`DU_NB_UART-1:0] i_rx_data;
    logic                   o_rd;
    logic                   i_tx_full;
    logic                   o_tx_wr;
    logic [`DU_NB_UART-1:0] o_tx_data;
    logic                   o_done;

    // Receive FIFO model, tag marks the last byte of a dump frame
    logic [`DU_NB_UART-1:0] rx_q[$];
    bit                     rx_tag_q[$];
    // Scoreboard
    logic [`DU_NB_UART-1:0] exp_q[$];
    int                     dump_len_q[$];
    logic [`DU_NB_DATA-1:0] shadow [`DU_MEM_WORDS];
    logic [`DU_NB_UART-1:0] exp_byte;
    integer                 seed = 39;
    logic                   stall_en;
    logic                   idle_check;
    logic                   dump_inflight;
    int                     dumps_sent;
    int                     done_cnt;
    int                     bytes_in_dump;
    int                     exp_len;
    int                     mismatch_errs;
    int                     protocol_errs;
    int                     other_errs;

    tb_clkgen u_clkgen (
        .o_clk (clk),
        .o_rst (i_rst)
    );

    du_dmem_link DUT (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_rx_done (i_rx_done),
        .i_rx_data (i_rx_data),
        .o_rd      (o_rd),
        .i_tx_full (i_tx_full),
        .o_tx_wr   (o_tx_wr),
        .o_tx_data (o_tx_data),
        .o_done    (o_done)
    );

    task automatic push_rx_byte(input logic [7:0] b, input bit ends_dump);
        rx_q.push_back(b);
        rx_tag_q.push_back(ends_dump);
    endtask

    task automatic send_write(input logic [4:0] addr, input logic [31:0] data);
        push_rx_byte(OP_WRITE, 1'b0);
        push_rx_byte({3'b000, addr}, 1'b0);
        for (int i = 0; i < 4; i++) begin
            push_rx_byte(data[8*i +: 8], 1'b0);
        end
        shadow[addr] = data;
    endtask

    // Expected bytes come from the shadow memory as it stands at this point
    task automatic send_dump(input logic [4:0] addr, input logic [4:0] cnt);
        logic [4:0] a;
        push_rx_byte(OP_DUMP, 1'b0);
        push_rx_byte({3'b000, addr}, 1'b0);
        push_rx_byte({3'b000, cnt}, 1'b1);
        a = addr;
        for (int w = 0; w <= cnt; w++) begin
            for (int i = 0; i < 4; i++) begin
                exp_q.push_back(shadow[a][8*i +: 8]);
            end
            a = a + 5'd1;
        end
        dump_len_q.push_back(4 * (cnt + 1));
        dumps_sent = dumps_sent + 1;
    endtask

    task automatic wait_for_dumps();
        while (done_cnt != dumps_sent) @(negedge clk);
    endtask

    // Inputs change on the falling edge only
    always @(negedge clk) begin
        i_rx_done = (rx_q.size() != 0);
        if (rx_q.size() != 0) begin
            i_rx_data = rx_q[0];
        end else begin
            i_rx_data = '0;
        end
        if (stall_en) begin
            i_tx_full = ($random(seed) % 2) != 0;
        end else begin
            i_tx_full = 1'b0;
        end
    end

    // FIFO pops and output scoreboard
    always @(posedge clk) begin
        if (o_done) begin
            done_cnt = done_cnt + 1;
            dump_inflight <= 1'b0;
            if (dump_len_q.size() == 0) begin
                other_errs = other_errs + 1;
                $display("ERROR at %0t: o_done pulsed with no dump pending", $time);
            end else begin
                exp_len = dump_len_q.pop_front();
                assert (bytes_in_dump == exp_len) else begin
                    mismatch_errs = mismatch_errs + 1;
                    $display("MISMATCH at %0t: o_done after %0d bytes, expected %0d",
                             $time, bytes_in_dump, exp_len);
                end
            end
            bytes_in_dump = 0;
        end
        if (o_tx_wr) begin
            bytes_in_dump = bytes_in_dump + 1;
            if (exp_q.size() == 0) begin
                other_errs = other_errs + 1;
                $display("ERROR at %0t: unexpected transmit byte %02h", $time, o_tx_data);
            end else begin
                exp_byte = exp_q.pop_front();
                assert (o_tx_data == exp_byte) else begin
                    mismatch_errs = mismatch_errs + 1;
                    $display("MISMATCH at %0t: tx byte %02h, expected %02h",
                             $time, o_tx_data, exp_byte);
                end
            end
        end
        if (o_rd && i_rx_done) begin
            if (rx_tag_q[0]) begin
                dump_inflight <= 1'b1;
            end
            void'(rx_q.pop_front());
            void'(rx_tag_q.pop_front());
        end
    end

    quiet_outputs: assert property (@(posedge clk) idle_check |-> (!o_rd && !o_tx_wr && !o_done))
        else begin
            protocol_errs = protocol_errs + 1;
            $display("ERROR at %0t: output active during reset or idle", $time);
        end

    no_wr_when_full: assert property (@(posedge clk) disable iff (i_rst) !(o_tx_wr && i_tx_full))
        else begin
            protocol_errs = protocol_errs + 1;
            $display("ERROR at %0t: o_tx_wr high while i_tx_full high", $time);
        end

    // Receive side holds off from the dump frame's last pop up to o_done
    no_pop_in_dump: assert property (@(posedge clk) disable iff (i_rst)
                                     (dump_inflight && !o_done) |-> !o_rd)
        else begin
            protocol_errs = protocol_errs + 1;
            $display("ERROR at %0t: receive FIFO popped during a dump", $time);
        end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR at %0t: timeout, %0d of %0d dumps finished", $time, done_cnt, dumps_sent);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        i_rx_done     = 1'b0;
        i_rx_data     = '0;
        i_tx_full     = 1'b0;
        stall_en      = 1'b0;
        idle_check    = 1'b0;
        dump_inflight = 1'b0;
        dumps_sent    = 0;
        done_cnt      = 0;
        bytes_in_dump = 0;
        mismatch_errs = 0;
        protocol_errs = 0;
        other_errs    = 0;

        // Quiet through reset and an idle stretch
        @(negedge clk);
        idle_check = 1'b1;
        while (i_rst) @(negedge clk);
        repeat (20) @(negedge clk);
        idle_check = 1'b0;

        // Single word round trip
        send_write(5'd5, $random(seed));
        send_dump(5'd5, 5'd0);
        wait_for_dumps();

        // Range that wraps past the top address
        for (int i = 0; i < 4; i++) begin
            send_write(5'(30 + i), $random(seed));
        end
        send_dump(5'd30, 5'd3);
        wait_for_dumps();

        // Same range without and with a stalling transmit FIFO
        for (int i = 0; i < 6; i++) begin
            send_write(5'(10 + i), $random(seed));
        end
        send_dump(5'd10, 5'd5);
        wait_for_dumps();
        stall_en = 1'b1;
        send_dump(5'd10, 5'd5);
        wait_for_dumps();
        stall_en = 1'b0;

        // Unknown opcode ahead of a normal frame
        push_rx_byte(8'h7E, 1'b0);
        send_write(5'd20, $random(seed));
        send_dump(5'd20, 5'd0);
        wait_for_dumps();

        // Frames queued behind a dump must wait for it
        send_write(5'd8, $random(seed));
        send_write(5'd9, $random(seed));
        send_dump(5'd8, 5'd1);
        send_write(5'd8, $random(seed));
        send_dump(5'd8, 5'd0);
        wait_for_dumps();

        repeat (5) @(negedge clk);
        assert (rx_q.size() == 0 && exp_q.size() == 0) else begin
            other_errs = other_errs + 1;
            $display("ERROR at %0t: %0d command bytes and %0d expected bytes left over",
                     $time, rx_q.size(), exp_q.size());
        end

        $display("Errors: %0d mismatch, %0d protocol, %0d other",
                 mismatch_errs, protocol_errs, other_errs);
        if (mismatch_errs + protocol_errs + other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/du_pkg.sv
src/du_cmd_rx.sv
src/du_dmem.sv
src/du_dmem_tx.sv
src/du_dmem_link.sv
testbench/tb_clkgen.sv
testbench/tb_du_dmem_link.sv

//--- run.sh
#!/bin/sh
# Build and run the data memory link testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_du_dmem_link -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
exit 0
